// ==== include/cpu_macros.svh ====
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// ####################
// Datapath sizes
// ####################

`define CPU_XLEN        32
`define CPU_REG_ADDR_W  5
`define CPU_NUM_REGS    32

// ####################
// Fetch and bubbles
// ####################

// First fetch address out of reset.
`define CPU_RESET_PC    32'h0000_0000

// ADDI x0, x0, 0.
`define CPU_NOP_INSTR   32'h0000_0013

`endif

// ==== hdl/rv_isa_pkg.sv ====
`include "cpu_macros.svh"

package rv_isa_pkg;

  typedef logic [`CPU_XLEN-1:0]       word_t;
  typedef logic [31:0]                instr_t;
  typedef logic [`CPU_REG_ADDR_W-1:0] reg_addr_t;

  // Major opcodes in instr[6:0].
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    BRANCH = 7'b1100011
  } opcode_e;

  typedef enum logic [3:0] {
    ADD,
    SUB,
    AND,
    OR,
    XOR,
    SLT,
    SLTU,
    SLL,
    SRL,
    SRA
  } alu_op_e;

endpackage

// ==== hdl/pipe_pkg.sv ====
package pipe_pkg;

  import rv_isa_pkg::*;

  // How execute picks the ALU operation.
  typedef logic [1:0] alu_class_t;

  localparam alu_class_t ALU_CLASS_ADD    = 2'd0;  // Address calc.
  localparam alu_class_t ALU_CLASS_BRANCH = 2'd1;  // Compare by subtract.
  localparam alu_class_t ALU_CLASS_FUNCT  = 2'd2;  // From funct3/funct7.

  typedef struct packed {
    logic       reg_write;
    logic       mem_read;
    logic       mem_write;
    logic       branch;
    logic       branch_ne;
    logic       alu_src;    // Operand b from imm.
    logic       is_imm_op;
    alu_class_t alu_class;
  } ctrl_t;

  typedef struct packed {
    ctrl_t      ctrl;
    word_t      pc;
    word_t      rs1_data;
    word_t      rs2_data;
    word_t      imm;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    reg_addr_t  rd;
    logic [2:0] funct3;
    logic       funct7_b5;
  } id_ex_t;

  typedef struct packed {
    logic      reg_write;
    logic      mem_read;
    logic      mem_write;
    word_t     alu_result;
    word_t     store_data;
    reg_addr_t rd;
  } ex_mem_t;

  typedef struct packed {
    logic      reg_write;
    logic      mem_to_reg;
    word_t     alu_result;
    word_t     load_data;
    reg_addr_t rd;
  } mem_wb_t;

  // A later stage seen as a forwarding source.
  typedef struct packed {
    word_t     data;
    reg_addr_t rd;
    logic      reg_write;
  } fwd_src_t;

endpackage

// ==== hdl/decode.sv ====
`timescale 1ns/10ps

module decode (
  input  rv_isa_pkg::instr_t    instr,
  output pipe_pkg::ctrl_t       ctrl,
  output rv_isa_pkg::reg_addr_t rs1,
  output rv_isa_pkg::reg_addr_t rs2,
  output rv_isa_pkg::reg_addr_t rd,
  output rv_isa_pkg::word_t     imm
);

  import rv_isa_pkg::*;
  import pipe_pkg::*;

  logic [2:0] funct3;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;

  assign funct3 = instr[14:12];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];
  assign rd     = instr[11:7];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};

  always_comb begin
    ctrl = '0;
    imm  = imm_i;
    case (instr[6:0])
      OP: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_class = ALU_CLASS_FUNCT;
      end
      OP_IMM: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_src   = 1'b1;
        ctrl.is_imm_op = 1'b1;
        ctrl.alu_class = ALU_CLASS_FUNCT;
      end
      LOAD: begin
        ctrl.reg_write = 1'b1;
        ctrl.mem_read  = 1'b1;
        ctrl.alu_src   = 1'b1;
        ctrl.alu_class = ALU_CLASS_ADD;  // Word loads only.
      end
      STORE: begin
        ctrl.mem_write = 1'b1;
        ctrl.alu_src   = 1'b1;
        ctrl.alu_class = ALU_CLASS_ADD;
        imm            = imm_s;
      end
      BRANCH: begin
        imm = imm_b;
        // Only BEQ and BNE; other compares fall through as NOPs.
        if (funct3 == 3'b000 || funct3 == 3'b001) begin
          ctrl.branch    = 1'b1;
          ctrl.branch_ne = funct3[0];
          ctrl.alu_class = ALU_CLASS_BRANCH;
        end
      end
      default: ctrl = '0;  // Unknown opcode is a NOP.
    endcase
  end

endmodule

// ==== hdl/regfile.sv ====
`timescale 1ns/10ps
`include "cpu_macros.svh"

module regfile (
  input  logic                  clk,
  input  logic                  arst_n,
  input  rv_isa_pkg::reg_addr_t rs1,
  input  rv_isa_pkg::reg_addr_t rs2,
  output rv_isa_pkg::word_t     rs1_data,
  output rv_isa_pkg::word_t     rs2_data,
  input  logic                  wr_en,
  input  rv_isa_pkg::reg_addr_t wr_addr,
  input  rv_isa_pkg::word_t     wr_data
);

  import rv_isa_pkg::*;

  word_t regs [1:`CPU_NUM_REGS-1];  // No storage for x0.

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 1; i < `CPU_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && wr_addr != '0) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // Write in the same cycle wins over the stored value.
  function automatic word_t read_port(reg_addr_t addr);
    if (addr == '0) begin
      return '0;
    end
    if (wr_en && wr_addr == addr) begin
      return wr_data;
    end
    return regs[addr];
  endfunction

  always_comb rs1_data = read_port(rs1);
  always_comb rs2_data = read_port(rs2);

endmodule

// ==== hdl/execute.sv ====
`timescale 1ns/10ps
`include "cpu_macros.svh"

module execute (
  input  pipe_pkg::id_ex_t   id_ex,
  input  pipe_pkg::fwd_src_t mem_src,
  input  pipe_pkg::fwd_src_t wb_src,
  output rv_isa_pkg::word_t  alu_result,
  output rv_isa_pkg::word_t  store_data,
  output logic               branch_taken,
  output rv_isa_pkg::word_t  branch_target
);

  import rv_isa_pkg::*;
  import pipe_pkg::*;

  word_t                        op_a;
  word_t                        rs2_val;
  word_t                        op_b;
  alu_op_e                      alu_op;
  logic [$clog2(`CPU_XLEN)-1:0] shamt;
  logic                         is_zero;

  // Memory stage is the younger result, so it is checked first.
  function automatic word_t forward(reg_addr_t rs, word_t reg_val,
                                    fwd_src_t mem_s, fwd_src_t wb_s);
    if (mem_s.reg_write && mem_s.rd != '0 && mem_s.rd == rs) begin
      return mem_s.data;
    end
    if (wb_s.reg_write && wb_s.rd != '0 && wb_s.rd == rs) begin
      return wb_s.data;
    end
    return reg_val;
  endfunction

  assign op_a       = forward(id_ex.rs1, id_ex.rs1_data, mem_src, wb_src);
  assign rs2_val    = forward(id_ex.rs2, id_ex.rs2_data, mem_src, wb_src);
  assign op_b       = id_ex.ctrl.alu_src ? id_ex.imm : rs2_val;
  assign store_data = rs2_val;
  assign shamt      = op_b[$clog2(`CPU_XLEN)-1:0];

  always_comb begin
    case (id_ex.ctrl.alu_class)
      ALU_CLASS_BRANCH: alu_op = SUB;
      ALU_CLASS_FUNCT: begin
        case (id_ex.funct3)
          3'b000:  alu_op = (id_ex.funct7_b5 && !id_ex.ctrl.is_imm_op) ? SUB : ADD;
          3'b001:  alu_op = SLL;
          3'b010:  alu_op = SLT;
          3'b011:  alu_op = SLTU;
          3'b100:  alu_op = XOR;
          3'b101:  alu_op = id_ex.funct7_b5 ? SRA : SRL;  // SRAI sets bit 30 too.
          3'b110:  alu_op = OR;
          default: alu_op = AND;
        endcase
      end
      default: alu_op = ADD;
    endcase
  end

  always_comb begin
    case (alu_op)
      SUB:     alu_result = op_a - op_b;
      AND:     alu_result = op_a & op_b;
      OR:      alu_result = op_a | op_b;
      XOR:     alu_result = op_a ^ op_b;
      SLT:     alu_result = word_t'($signed(op_a) < $signed(op_b));
      SLTU:    alu_result = word_t'(op_a < op_b);
      SLL:     alu_result = op_a << shamt;
      SRL:     alu_result = op_a >> shamt;
      SRA:     alu_result = $unsigned($signed(op_a) >>> shamt);
      default: alu_result = op_a + op_b;
    endcase
  end

  // BEQ/BNE from the subtract result.
  assign is_zero       = (alu_result == '0);
  assign branch_taken  = id_ex.ctrl.branch & (is_zero ^ id_ex.ctrl.branch_ne);
  assign branch_target = id_ex.pc + id_ex.imm;

endmodule

// ==== hdl/hazard_unit.sv ====
`timescale 1ns/10ps

module hazard_unit (
  input  rv_isa_pkg::reg_addr_t rs1,
  input  rv_isa_pkg::reg_addr_t rs2,
  input  rv_isa_pkg::reg_addr_t id_ex_rd,
  input  logic                  id_ex_mem_read,
  input  logic                  branch_taken,
  output logic                  pc_stall,
  output logic                  if_id_stall,
  output logic                  id_ex_flush,
  output logic                  if_id_flush
);

  logic load_use;

  // Load in execute feeding the instruction in decode.
  assign load_use = id_ex_mem_read && (id_ex_rd != '0) &&
                    (id_ex_rd == rs1 || id_ex_rd == rs2);

  // Taken branch kills both younger instructions.
  assign if_id_flush = branch_taken;
  assign id_ex_flush = branch_taken | load_use;  // Bubble behind the load.

  // Flush wins; a stalled decode slot is dropped anyway.
  assign pc_stall    = load_use & ~branch_taken;
  assign if_id_stall = load_use & ~branch_taken;

endmodule

// ==== hdl/cpu.sv ====
`timescale 1ns/10ps
`include "cpu_macros.svh"

module cpu (
  input  logic               clk,
  input  logic               arst_n,
  output rv_isa_pkg::word_t  imem_addr,
  output logic               imem_valid,
  input  rv_isa_pkg::instr_t imem_instr,
  output rv_isa_pkg::word_t  dmem_addr,
  output rv_isa_pkg::word_t  dmem_write_data,
  output logic               dmem_valid,
  output logic               dmem_mem_read,
  output logic               dmem_mem_write,
  input  rv_isa_pkg::word_t  dmem_read_data
);

  import rv_isa_pkg::*;
  import pipe_pkg::*;

  word_t     pc;
  instr_t    if_id_instr;
  word_t     if_id_pc;
  id_ex_t    id_ex;
  id_ex_t    id_ex_next;
  ex_mem_t   ex_mem;
  ex_mem_t   ex_mem_next;
  mem_wb_t   mem_wb;
  mem_wb_t   mem_wb_next;

  ctrl_t     dec_ctrl;
  reg_addr_t dec_rs1;
  reg_addr_t dec_rs2;
  reg_addr_t dec_rd;
  word_t     dec_imm;
  word_t     rs1_data;
  word_t     rs2_data;

  word_t     alu_result;
  word_t     store_data;
  word_t     branch_target;
  logic      branch_taken;
  fwd_src_t  mem_src;
  fwd_src_t  wb_src;
  word_t     wb_data;

  logic      pc_stall;
  logic      if_id_stall;
  logic      id_ex_flush;
  logic      if_id_flush;

  // ####################
  // Fetch
  // ####################

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc <= `CPU_RESET_PC;
    end else if (branch_taken) begin
      pc <= branch_target;  // Redirect from execute.
    end else if (!pc_stall) begin
      pc <= pc + word_t'(4);
    end
  end

  assign imem_addr  = pc;
  assign imem_valid = ~if_id_stall;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      if_id_instr <= `CPU_NOP_INSTR;
      if_id_pc    <= '0;
    end else if (if_id_flush) begin
      if_id_instr <= `CPU_NOP_INSTR;
    end else if (!if_id_stall) begin
      if_id_instr <= imem_instr;
      if_id_pc    <= pc;
    end
  end

  // ####################
  // Decode
  // ####################

  decode u_decode (
    .instr (if_id_instr),
    .ctrl  (dec_ctrl),
    .rs1   (dec_rs1),
    .rs2   (dec_rs2),
    .rd    (dec_rd),
    .imm   (dec_imm)
  );

  regfile u_regfile (
    .clk      (clk),
    .arst_n   (arst_n),
    .rs1      (dec_rs1),
    .rs2      (dec_rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wr_en    (mem_wb.reg_write),
    .wr_addr  (mem_wb.rd),
    .wr_data  (wb_data)
  );

  hazard_unit u_hazard_unit (
    .rs1            (dec_rs1),
    .rs2            (dec_rs2),
    .id_ex_rd       (id_ex.rd),
    .id_ex_mem_read (id_ex.ctrl.mem_read),
    .branch_taken   (branch_taken),
    .pc_stall       (pc_stall),
    .if_id_stall    (if_id_stall),
    .id_ex_flush    (id_ex_flush),
    .if_id_flush    (if_id_flush)
  );

  always_comb begin
    id_ex_next.ctrl      = dec_ctrl;
    id_ex_next.pc        = if_id_pc;
    id_ex_next.rs1_data  = rs1_data;
    id_ex_next.rs2_data  = rs2_data;
    id_ex_next.imm       = dec_imm;
    id_ex_next.rs1       = dec_rs1;
    id_ex_next.rs2       = dec_rs2;
    id_ex_next.rd        = dec_rd;
    id_ex_next.funct3    = if_id_instr[14:12];
    id_ex_next.funct7_b5 = if_id_instr[30];
  end

  // ####################
  // Execute
  // ####################

  assign mem_src = '{data: ex_mem.alu_result, rd: ex_mem.rd, reg_write: ex_mem.reg_write};
  assign wb_src  = '{data: wb_data, rd: mem_wb.rd, reg_write: mem_wb.reg_write};

  execute u_execute (
    .id_ex         (id_ex),
    .mem_src       (mem_src),
    .wb_src        (wb_src),
    .alu_result    (alu_result),
    .store_data    (store_data),
    .branch_taken  (branch_taken),
    .branch_target (branch_target)
  );

  always_comb begin
    ex_mem_next.reg_write  = id_ex.ctrl.reg_write;
    ex_mem_next.mem_read   = id_ex.ctrl.mem_read;
    ex_mem_next.mem_write  = id_ex.ctrl.mem_write;
    ex_mem_next.alu_result = alu_result;
    ex_mem_next.store_data = store_data;
    ex_mem_next.rd         = id_ex.rd;
  end

  // ####################
  // Memory / writeback
  // ####################

  assign dmem_addr       = ex_mem.alu_result;
  assign dmem_write_data = ex_mem.store_data;
  assign dmem_mem_read   = ex_mem.mem_read;
  assign dmem_mem_write  = ex_mem.mem_write;
  assign dmem_valid      = ex_mem.mem_read | ex_mem.mem_write;

  always_comb begin
    mem_wb_next.reg_write  = ex_mem.reg_write;
    mem_wb_next.mem_to_reg = ex_mem.mem_read;
    mem_wb_next.alu_result = ex_mem.alu_result;
    mem_wb_next.load_data  = dmem_read_data;  // Same-cycle read.
    mem_wb_next.rd         = ex_mem.rd;
  end

  assign wb_data = mem_wb.mem_to_reg ? mem_wb.load_data : mem_wb.alu_result;

  // Pipeline registers; a zero ctrl field is a bubble.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      id_ex  <= '0;
      ex_mem <= '0;
      mem_wb <= '0;
    end else begin
      if (id_ex_flush) begin
        id_ex <= '0;
      end else begin
        id_ex <= id_ex_next;
      end
      ex_mem <= ex_mem_next;
      mem_wb <= mem_wb_next;
    end
  end

endmodule

// ==== tb/cpu_checker.sv ====
`timescale 1ns/10ps

module cpu_checker (
  input logic              clk,
  input logic              arst_n,
  input rv_isa_pkg::word_t imem_addr,
  input logic              dmem_valid,
  input logic              dmem_mem_read,
  input logic              dmem_mem_write
);

  int unsigned assert_fails = 0;

  // ####################
  // Port protocol
  // ####################

  rd_wr_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
    !(dmem_mem_read && dmem_mem_write))
    else begin
      $error("dmem read and write strobes high in the same cycle");
      assert_fails++;
    end

  fetch_aligned: assert property (@(posedge clk) disable iff (!arst_n)
    imem_addr[1:0] == 2'b00)
    else begin
      $error("imem_addr not word aligned: 0x%h", imem_addr);
      assert_fails++;
    end

  // No memory access while held in reset.
  quiet_in_reset: assert property (@(posedge clk) !arst_n |-> !dmem_valid)
    else begin
      $error("dmem_valid high during reset");
      assert_fails++;
    end

endmodule

bind cpu cpu_checker u_checker (
  .clk            (clk),
  .arst_n         (arst_n),
  .imem_addr      (imem_addr),
  .dmem_valid     (dmem_valid),
  .dmem_mem_read  (dmem_mem_read),
  .dmem_mem_write (dmem_mem_write)
);

// ==== tb/cpu_tb.sv ====
`timescale 1ns/10ps
`include "cpu_macros.svh"

module cpu_tb;

  import rv_isa_pkg::*;

  localparam int reset_cycles     = 16;
  localparam int cycles_per_instr = 20;
  localparam int max_ref_steps    = 1000;

  logic   clk = 1'b0;
  logic   arst_n;
  word_t  imem_addr;
  logic   imem_valid;
  instr_t imem_instr;
  word_t  dmem_addr;
  word_t  dmem_write_data;
  logic   dmem_valid;
  logic   dmem_mem_read;
  logic   dmem_mem_write;
  word_t  dmem_read_data;

  instr_t imem [0:63];
  word_t  dmem [0:63];
  word_t  ref_mem [0:63];
  word_t  ref_regs [0:31];
  word_t  exp_addr_q [$];
  word_t  exp_data_q [$];
  int     prog_len  = 0;
  int     store_idx = 0;
  integer seed      = 32'h3ccb_e4fa;

  always #5 clk = ~clk;

  cpu uut (
    .clk             (clk),
    .arst_n          (arst_n),
    .imem_addr       (imem_addr),
    .imem_valid      (imem_valid),
    .imem_instr      (imem_instr),
    .dmem_addr       (dmem_addr),
    .dmem_write_data (dmem_write_data),
    .dmem_valid      (dmem_valid),
    .dmem_mem_read   (dmem_mem_read),
    .dmem_mem_write  (dmem_mem_write),
    .dmem_read_data  (dmem_read_data)
  );

  // ####################
  // Memory models
  // ####################

  assign imem_instr     = imem[imem_addr[7:2]];
  assign dmem_read_data = dmem[dmem_addr[7:2]];  // Same-cycle read.

  always @(posedge clk) begin
    if (dmem_valid && dmem_mem_write) begin
      dmem[dmem_addr[7:2]] <= dmem_write_data;
    end
  end

  // ####################
  // Encoders
  // ####################

  function automatic instr_t r_type(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                    logic [2:0] f3, reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic instr_t i_type(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
                                    reg_addr_t rd, logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic instr_t s_type(logic [11:0] imm, reg_addr_t rs2, reg_addr_t rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic instr_t b_type(logic [12:0] imm, reg_addr_t rs2, reg_addr_t rs1,
                                    logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  task automatic emit(instr_t ins);
    imem[prog_len] = ins;
    prog_len++;
  endtask

  task automatic build_program();
    for (int i = 0; i < 64; i++) begin
      imem[i] = `CPU_NOP_INSTR;
    end
    emit(i_type(12'd0, 5'd0, 3'd2, 5'd1, LOAD));         // lw   x1, 0(x0)
    emit(i_type(12'd4, 5'd0, 3'd2, 5'd2, LOAD));         // lw   x2, 4(x0)
    emit(r_type(7'h00, 5'd2, 5'd1, 3'd0, 5'd3));         // add  x3, x1, x2  (load-use)
    emit(s_type(12'd128, 5'd3, 5'd0));                   // sw   x3, 128(x0)
    emit(r_type(7'h20, 5'd2, 5'd1, 3'd0, 5'd4));         // sub  x4, x1, x2
    emit(r_type(7'h00, 5'd2, 5'd4, 3'd7, 5'd5));         // and  x5, x4, x2
    emit(r_type(7'h00, 5'd5, 5'd4, 3'd6, 5'd6));         // or   x6, x4, x5
    emit(s_type(12'd132, 5'd4, 5'd0));
    emit(s_type(12'd136, 5'd5, 5'd0));
    emit(s_type(12'd140, 5'd6, 5'd0));
    emit(r_type(7'h00, 5'd2, 5'd1, 3'd4, 5'd7));         // xor  x7
    emit(r_type(7'h00, 5'd2, 5'd1, 3'd2, 5'd8));         // slt  x8
    emit(r_type(7'h00, 5'd2, 5'd1, 3'd3, 5'd9));         // sltu x9
    emit(r_type(7'h00, 5'd2, 5'd1, 3'd1, 5'd10));        // sll  x10
    emit(r_type(7'h00, 5'd2, 5'd1, 3'd5, 5'd11));        // srl  x11
    emit(r_type(7'h20, 5'd2, 5'd1, 3'd5, 5'd12));        // sra  x12
    for (int r = 7; r <= 12; r++) begin
      emit(s_type(12'(144 + 4 * (r - 7)), reg_addr_t'(r), 5'd0));
    end
    emit(i_type(12'hffb, 5'd1, 3'd0, 5'd13, OP_IMM));    // addi  x13, x1, -5
    emit(i_type(12'h0f0, 5'd1, 3'd7, 5'd14, OP_IMM));    // andi  x14
    emit(i_type(12'hf00, 5'd13, 3'd6, 5'd15, OP_IMM));   // ori   x15, x13, -256
    emit(i_type(12'h555, 5'd1, 3'd4, 5'd16, OP_IMM));    // xori  x16
    emit(i_type(12'd100, 5'd1, 3'd2, 5'd17, OP_IMM));    // slti  x17
    emit(i_type(12'hfff, 5'd1, 3'd3, 5'd18, OP_IMM));    // sltiu x18
    emit(i_type(12'h007, 5'd1, 3'd1, 5'd19, OP_IMM));    // slli  x19
    emit(i_type(12'h009, 5'd1, 3'd5, 5'd20, OP_IMM));    // srli  x20
    emit(i_type(12'h40d, 5'd1, 3'd5, 5'd21, OP_IMM));    // srai  x21
    for (int r = 13; r <= 21; r++) begin
      emit(s_type(12'(168 + 4 * (r - 13)), reg_addr_t'(r), 5'd0));
    end
    emit(i_type(12'd1, 5'd1, 3'd0, 5'd0, OP_IMM));       // addi x0, x1, 1
    emit(s_type(12'd204, 5'd0, 5'd0));                   // sw   x0, 204(x0)
    emit(b_type(13'd12, 5'd1, 5'd1, 3'd0));              // beq  taken
    emit(s_type(12'd208, 5'd1, 5'd0));
    emit(s_type(12'd212, 5'd2, 5'd0));
    emit(b_type(13'd12, 5'd1, 5'd1, 3'd1));              // bne  not taken
    emit(s_type(12'd216, 5'd1, 5'd0));
    emit(i_type(12'd3, 5'd0, 3'd0, 5'd24, OP_IMM));      // addi x24, x0, 3
    emit(b_type(13'd12, 5'd0, 5'd24, 3'd1));             // bne  x24, x0 (forwarded)
    emit(s_type(12'd220, 5'd2, 5'd0));
    emit(s_type(12'd224, 5'd3, 5'd0));
    emit(b_type(13'd8, 5'd4, 5'd3, 3'd0));               // beq  x3, x4 (data dependent)
    emit(s_type(12'd228, 5'd6, 5'd0));
    emit(i_type(12'd128, 5'd0, 3'd2, 5'd22, LOAD));      // lw   x22, 128(x0)
    emit(i_type(12'd1, 5'd22, 3'd0, 5'd23, OP_IMM));     // addi x23, x22, 1
    emit(s_type(12'd232, 5'd23, 5'd0));
    emit(b_type(13'd0, 5'd0, 5'd0, 3'd0));               // Halt loop.
  endtask

  // ####################
  // Reference model
  // ####################

  // One instruction on the shadow state; returns the next pc.
  function automatic word_t ref_step(word_t pc);
    instr_t     ins;
    word_t      a;
    word_t      b;
    word_t      res;
    word_t      ea;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    logic [4:0] sh;
    logic [2:0] f3;
    reg_addr_t  rd;
    ins   = imem[pc[7:2]];
    f3    = ins[14:12];
    rd    = ins[11:7];
    a     = ref_regs[ins[19:15]];
    imm_i = {{20{ins[31]}}, ins[31:20]};
    imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
    b     = (ins[6:0] == OP) ? ref_regs[ins[24:20]] : imm_i;
    sh    = b[4:0];
    res   = '0;
    case (ins[6:0])
      OP, OP_IMM: begin
        case (f3)
          3'd0: res = (ins[6:0] == OP && ins[30]) ? a - b : a + b;
          3'd1: res = a << sh;
          3'd2: res = {31'd0, $signed(a) < $signed(b)};
          3'd3: res = {31'd0, a < b};
          3'd4: res = a ^ b;
          3'd5: begin
            if (ins[30]) begin
              res = $signed(a) >>> sh;
            end else begin
              res = a >> sh;
            end
          end
          3'd6: res = a | b;
          default: res = a & b;
        endcase
        if (rd != 0) begin
          ref_regs[rd] = res;
        end
      end
      LOAD: begin
        ea = a + imm_i;
        if (rd != 0) begin
          ref_regs[rd] = ref_mem[ea[7:2]];
        end
      end
      STORE: begin
        ea = a + imm_s;
        ref_mem[ea[7:2]] = ref_regs[ins[24:20]];
        exp_addr_q.push_back(ea);
        exp_data_q.push_back(ref_regs[ins[24:20]]);
      end
      BRANCH: begin
        if ((f3 == 3'd0 && a == ref_regs[ins[24:20]]) ||
            (f3 == 3'd1 && a != ref_regs[ins[24:20]])) begin
          return pc + imm_b;
        end
      end
      default: res = '0;  // Illegal opcode acts as a NOP.
    endcase
    return pc + 4;
  endfunction

  task automatic run_reference();
    word_t pc;
    word_t next_pc;
    int    steps;
    pc    = `CPU_RESET_PC;
    steps = 0;
    for (int r = 0; r < 32; r++) begin
      ref_regs[r] = '0;
    end
    next_pc = ref_step(pc);
    while (next_pc != pc && steps < max_ref_steps) begin  // Ends on the self-loop.
      pc      = next_pc;
      next_pc = ref_step(pc);
      steps++;
    end
  endtask

  // ####################
  // Checks
  // ####################

  task automatic abort_run(string why);
    $display("%s", why);
    $display("TEST FAIL");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic addr_check(string name, word_t expected, word_t actual);
    if (actual !== expected) begin
      abort_run($sformatf("CHECK FAILED %s address: expected 0x%h, actual 0x%h",
                          name, expected, actual));
    end
  endtask

  task automatic data_check(string name, word_t expected, word_t actual);
    if (actual !== expected) begin
      abort_run($sformatf("CHECK FAILED %s data: expected 0x%h, actual 0x%h",
                          name, expected, actual));
    end
  endtask

  task automatic flag_check(string name, logic expected, logic actual);
    if (actual !== expected) begin
      abort_run($sformatf("CHECK FAILED %s: expected %b, actual %b",
                          name, expected, actual));
    end
  endtask

  // Write strobes are stable by the falling edge.
  always @(negedge clk) begin
    if (dmem_valid && dmem_mem_write) begin
      if (store_idx >= exp_addr_q.size()) begin
        abort_run($sformatf("unexpected extra store to address 0x%h", dmem_addr));
      end else begin
        addr_check($sformatf("store %0d", store_idx), exp_addr_q[store_idx], dmem_addr);
        data_check($sformatf("store %0d", store_idx), exp_data_q[store_idx],
                   dmem_write_data);
        store_idx++;
      end
    end
  end

  initial begin : watchdog
    @(posedge arst_n);
    repeat (cycles_per_instr * prog_len) @(posedge clk);
    abort_run($sformatf("timeout: program did not finish, %0d of %0d stores seen",
                        store_idx, exp_addr_q.size()));
  end

  initial begin : main
    word_t fill;
    arst_n = 1'b0;
    build_program();
    for (int i = 0; i < 64; i++) begin
      fill = $random(seed);
      dmem[i] <= fill;
      ref_mem[i] = fill;
    end
    run_reference();
    repeat (reset_cycles) @(negedge clk);
    // Port state while held in reset.
    addr_check("reset fetch", `CPU_RESET_PC, imem_addr);
    flag_check("reset imem_valid", 1'b1, imem_valid);
    flag_check("reset dmem_valid", 1'b0, dmem_valid);
    flag_check("reset dmem_mem_read", 1'b0, dmem_mem_read);
    flag_check("reset dmem_mem_write", 1'b0, dmem_mem_write);
    arst_n = 1'b1;
    wait (store_idx == exp_addr_q.size());
    repeat (10) @(negedge clk);  // Room for a stray store to show up.
    for (int i = 0; i < 64; i++) begin
      data_check($sformatf("final mem word %0d", i), ref_mem[i], dmem[i]);
    end
    if (uut.u_checker.assert_fails == 0) begin
      $display("TEST PASS");
      $finish;
    end else begin
      abort_run("port protocol assertions failed during the run");
    end
  end

endmodule

// ==== verilog.f ====
+incdir+include
hdl/rv_isa_pkg.sv
hdl/pipe_pkg.sv
hdl/decode.sv
hdl/regfile.sv
hdl/execute.sv
hdl/hazard_unit.sv
hdl/cpu.sv
tb/cpu_checker.sv
tb/cpu_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build with Verilator and run; success only when the pass line is printed.
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert -Wno-fatal --top-module cpu_tb -f verilog.f &&
  { out="$(./obj_dir/Vcpu_tb 2>&1)"; echo "$out"; grep -qx "TEST PASS" <<< "$out"; } &&
  echo "simulation passed" ||
  { echo "simulation failed" >&2; exit 1; }
